// File: hw/proxy_regs_pkg.sv
package proxy_regs_pkg;

    // ----------------------------------------------------------------------
    // AXI4-Lite bus widths and responses
    // ----------------------------------------------------------------------
    localparam int AXIL_ADDR_WID = 8;
    localparam int AXIL_DATA_WID = 32;

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'd0;
    localparam axil_resp_t RESP_SLVERR = 2'd2;

    // ----------------------------------------------------------------------
    // Register map
    // ----------------------------------------------------------------------
    // CTRL bit 0 starts playback, bit 1 enables capture
    // STATUS bit 0 is busy, upper half is the captured packet count
    typedef enum logic [AXIL_ADDR_WID-1:0] {
        REG_CTRL    = 8'h00,
        REG_PKT_LEN = 8'h04,
        REG_SEED    = 8'h08,
        REG_STATUS  = 8'h0C
    } reg_offset_t;

    // Capture window, one word per packet word
    localparam logic [AXIL_ADDR_WID-1:0] CAPTURE_BASE = 8'h40;

    // Playback settings handed from the register block to the producer
    typedef struct packed {
        logic [3:0]               len_m1;
        logic [AXIL_DATA_WID-1:0] seed;
    } playback_cfg_t;

endpackage

// File: hw/packet_pkg.sv
package packet_pkg;

    // Packet word and index sizes
    localparam int PKT_DATA_WID  = 32;
    localparam int MAX_PKT_WORDS = 16;
    localparam int PKT_IDX_WID   = 4;

    // Words buffered between playback and capture
    localparam int FIFO_DEPTH = 8;

    // Width of the captured packet counter
    localparam int PKT_COUNT_WID = 16;

    typedef logic [PKT_DATA_WID-1:0] pkt_word_t;
    typedef logic [PKT_IDX_WID-1:0]  pkt_idx_t;

endpackage

// File: hw/packet_if.sv
`timescale 1ns/1ps

interface packet_if;

    import packet_pkg::*;

    // Word moves on a clock edge where valid and ready are both high
    logic      valid;
    logic      ready;
    pkt_word_t data;
    logic      last;

    modport source (
        output valid,
        output data,
        output last,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  last,
        output ready
    );

endinterface

// File: hw/packet_playback.sv
`timescale 1ns/1ps

module packet_playback (
    input  logic                          clk,
    input  logic                          srst,
    input  logic                          i_start,
    input  proxy_regs_pkg::playback_cfg_t i_cfg,
    output logic                          o_busy,
    packet_if.source                      o_pkt
);

    import proxy_regs_pkg::*;
    import packet_pkg::*;

    typedef enum logic {
        IDLE,
        SEND
    } play_state_t;

    play_state_t   state;
    playback_cfg_t cfg_q;
    pkt_idx_t      word_idx;
    logic          is_last;
    logic          xfer;

    assign is_last = (word_idx == cfg_q.len_m1);
    assign xfer    = o_pkt.valid && o_pkt.ready;

    // ----------------------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // A start while sending is dropped here by design
                    if (i_start) begin
                        state    <= SEND;
                        word_idx <= '0;
                    end
                end
                SEND: begin
                    if (xfer) begin
                        word_idx <= word_idx + 1'b1;
                        if (is_last) begin
                            state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Settings are frozen for the whole packet
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start) begin
            cfg_q <= i_cfg;
        end
    end

    // Word i carries seed + i, wrapping at 32 bits
    assign o_pkt.valid = (state == SEND);
    assign o_pkt.data  = cfg_q.seed + pkt_word_t'(word_idx);
    assign o_pkt.last  = is_last;
    assign o_busy      = (state == SEND);

endmodule

// File: hw/packet_fifo.sv
`timescale 1ns/1ps

module packet_fifo (
    input  logic     clk,
    input  logic     srst,
    packet_if.sink   i_pkt,
    packet_if.source o_pkt
);

    import packet_pkg::*;

    // Storage for data and the end-of-packet flag
    pkt_word_t data_mem [FIFO_DEPTH];
    logic      last_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   fill;
    logic                          push;
    logic                          pop;

    assign push = i_pkt.valid && i_pkt.ready;
    assign pop  = o_pkt.valid && o_pkt.ready;

    // ----------------------------------------------------------------------
    // Pointers and fill level
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                fill <= fill + 1'b1;
            end else if (pop && !push) begin
                fill <= fill - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= i_pkt.data;
            last_mem[wr_ptr] <= i_pkt.last;
        end
    end

    // Full stops the producer, empty hides the output
    assign i_pkt.ready = (fill != FIFO_DEPTH);
    assign o_pkt.valid = (fill != 0);
    assign o_pkt.data  = data_mem[rd_ptr];
    assign o_pkt.last  = last_mem[rd_ptr];

endmodule

// File: hw/packet_capture.sv
`timescale 1ns/1ps

module packet_capture (
    input  logic                                clk,
    input  logic                                srst,
    packet_if.sink                              i_pkt,
    input  logic                                i_capture_en,
    input  packet_pkg::pkt_idx_t                i_rd_idx,
    output packet_pkg::pkt_word_t               o_rd_word,
    output logic [packet_pkg::PKT_COUNT_WID-1:0] o_pkt_count
);

    import packet_pkg::*;

    pkt_word_t cap_mem [MAX_PKT_WORDS];
    pkt_idx_t  wr_idx;
    logic      xfer;

    // Holding ready low backs the stream up into the FIFO
    assign i_pkt.ready = i_capture_en;
    assign xfer        = i_pkt.valid && i_pkt.ready;

    // ----------------------------------------------------------------------
    // Write index and packet counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_idx      <= '0;
            o_pkt_count <= '0;
        end else if (xfer) begin
            if (i_pkt.last) begin
                // Next packet lands at the start of memory
                wr_idx      <= '0;
                o_pkt_count <= o_pkt_count + 1'b1;
            end else begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Capture memory
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (xfer) begin
            cap_mem[wr_idx] <= i_pkt.data;
        end
    end

    // Registered read port for the register block
    always_ff @(posedge clk) begin
        o_rd_word <= cap_mem[i_rd_idx];
    end

endmodule

// File: hw/proxy_regs.sv
`timescale 1ns/1ps

module proxy_regs (
    input  logic                                      clk,
    input  logic                                      srst,
    input  logic                                      i_axil_awvalid,
    input  logic [proxy_regs_pkg::AXIL_ADDR_WID-1:0]  i_axil_awaddr,
    output logic                                      o_axil_awready,
    input  logic                                      i_axil_wvalid,
    input  logic [proxy_regs_pkg::AXIL_DATA_WID-1:0]  i_axil_wdata,
    output logic                                      o_axil_wready,
    output logic                                      o_axil_bvalid,
    output proxy_regs_pkg::axil_resp_t                o_axil_bresp,
    input  logic                                      i_axil_bready,
    input  logic                                      i_axil_arvalid,
    input  logic [proxy_regs_pkg::AXIL_ADDR_WID-1:0]  i_axil_araddr,
    output logic                                      o_axil_arready,
    output logic                                      o_axil_rvalid,
    output logic [proxy_regs_pkg::AXIL_DATA_WID-1:0]  o_axil_rdata,
    output proxy_regs_pkg::axil_resp_t                o_axil_rresp,
    input  logic                                      i_axil_rready,
    output logic                                      o_start,
    output proxy_regs_pkg::playback_cfg_t             o_cfg,
    input  logic                                      i_busy,
    output logic                                      o_capture_en,
    output packet_pkg::pkt_idx_t                      o_rd_idx,
    input  packet_pkg::pkt_word_t                     i_rd_word,
    input  logic [packet_pkg::PKT_COUNT_WID-1:0]      i_pkt_count
);

    import proxy_regs_pkg::*;
    import packet_pkg::*;

    logic                     wr_ready;
    logic                     wr_fire;
    logic                     rd_fire;
    logic                     rd_pend;
    logic [AXIL_ADDR_WID-1:0] rd_addr_q;
    reg_offset_t              wr_off;
    reg_offset_t              rd_off;

    // True for word-aligned offsets inside the capture window
    function automatic logic in_capture_window(input logic [AXIL_ADDR_WID-1:0] addr);
        return (addr >= CAPTURE_BASE) && (addr <= CAPTURE_BASE + (MAX_PKT_WORDS - 1) * 4) &&
               (addr[1:0] == 2'b00);
    endfunction

    assign wr_fire = wr_ready && i_axil_awvalid && i_axil_wvalid;
    assign rd_fire = o_axil_arready && i_axil_arvalid;
    assign wr_off  = reg_offset_t'(i_axil_awaddr);
    assign rd_off  = reg_offset_t'(rd_addr_q);

    assign o_axil_awready = wr_ready;
    assign o_axil_wready  = wr_ready;

    // Capture memory is addressed straight from the AR channel
    assign o_rd_idx = i_axil_araddr[PKT_IDX_WID+1:2];

    // ----------------------------------------------------------------------
    // Write channel and configuration registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ready      <= 1'b0;
            o_axil_bvalid <= 1'b0;
            o_start       <= 1'b0;
            o_capture_en  <= 1'b0;
            o_cfg         <= '0;
        end else begin
            wr_ready <= i_axil_awvalid && i_axil_wvalid && !wr_ready && !o_axil_bvalid;
            o_start  <= 1'b0;
            if (o_axil_bvalid && i_axil_bready) begin
                o_axil_bvalid <= 1'b0;
            end
            if (wr_fire) begin
                o_axil_bvalid <= 1'b1;
                o_axil_bresp  <= RESP_OKAY;
                case (wr_off)
                    REG_CTRL: begin
                        o_start      <= i_axil_wdata[0];
                        o_capture_en <= i_axil_wdata[1];
                    end
                    REG_PKT_LEN: o_cfg.len_m1 <= i_axil_wdata[3:0];
                    REG_SEED:    o_cfg.seed   <= i_axil_wdata;
                    // Read only, write has no effect
                    REG_STATUS:  o_axil_bresp <= RESP_OKAY;
                    default: begin
                        if (!in_capture_window(i_axil_awaddr)) begin
                            o_axil_bresp <= RESP_SLVERR;
                        end
                    end
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read channel
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            o_axil_arready <= 1'b0;
            o_axil_rvalid  <= 1'b0;
            rd_pend        <= 1'b0;
        end else begin
            o_axil_arready <= i_axil_arvalid && !o_axil_arready && !rd_pend && !o_axil_rvalid;
            rd_pend        <= rd_fire;
            if (o_axil_rvalid && i_axil_rready) begin
                o_axil_rvalid <= 1'b0;
            end
            if (rd_pend) begin
                o_axil_rvalid <= 1'b1;
            end
        end
    end

    // Read data is built once the capture word is back
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rd_addr_q <= i_axil_araddr;
        end
        if (rd_pend) begin
            o_axil_rresp <= RESP_OKAY;
            case (rd_off)
                REG_CTRL:    o_axil_rdata <= {{(AXIL_DATA_WID-2){1'b0}}, o_capture_en, 1'b0};
                REG_PKT_LEN: o_axil_rdata <= {{(AXIL_DATA_WID-4){1'b0}}, o_cfg.len_m1};
                REG_SEED:    o_axil_rdata <= o_cfg.seed;
                REG_STATUS: begin
                    o_axil_rdata <= {i_pkt_count, {(AXIL_DATA_WID-PKT_COUNT_WID-1){1'b0}}, i_busy};
                end
                default: begin
                    if (in_capture_window(rd_addr_q)) begin
                        o_axil_rdata <= i_rd_word;
                    end else begin
                        o_axil_rdata <= '0;
                        o_axil_rresp <= RESP_SLVERR;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/proxy_top.sv
`timescale 1ns/1ps

module proxy_top (
    input  logic                                     clk,
    input  logic                                     srst,
    input  logic                                     i_axil_awvalid,
    input  logic [proxy_regs_pkg::AXIL_ADDR_WID-1:0] i_axil_awaddr,
    output logic                                     o_axil_awready,
    input  logic                                     i_axil_wvalid,
    input  logic [proxy_regs_pkg::AXIL_DATA_WID-1:0] i_axil_wdata,
    output logic                                     o_axil_wready,
    output logic                                     o_axil_bvalid,
    output proxy_regs_pkg::axil_resp_t               o_axil_bresp,
    input  logic                                     i_axil_bready,
    input  logic                                     i_axil_arvalid,
    input  logic [proxy_regs_pkg::AXIL_ADDR_WID-1:0] i_axil_araddr,
    output logic                                     o_axil_arready,
    output logic                                     o_axil_rvalid,
    output logic [proxy_regs_pkg::AXIL_DATA_WID-1:0] o_axil_rdata,
    output proxy_regs_pkg::axil_resp_t               o_axil_rresp,
    input  logic                                     i_axil_rready
);

    import proxy_regs_pkg::*;
    import packet_pkg::*;

    logic                     start;
    playback_cfg_t            cfg;
    logic                     busy;
    logic                     capture_en;
    pkt_idx_t                 rd_idx;
    pkt_word_t                rd_word;
    logic [PKT_COUNT_WID-1:0] pkt_count;

    // Playback to FIFO, FIFO to capture
    packet_if play_if ();
    packet_if cap_if ();

    // ----------------------------------------------------------------------
    // Register slave
    // ----------------------------------------------------------------------
    proxy_regs proxy_regs_i (
        .clk,
        .srst,
        .i_axil_awvalid,
        .i_axil_awaddr,
        .o_axil_awready,
        .i_axil_wvalid,
        .i_axil_wdata,
        .o_axil_wready,
        .o_axil_bvalid,
        .o_axil_bresp,
        .i_axil_bready,
        .i_axil_arvalid,
        .i_axil_araddr,
        .o_axil_arready,
        .o_axil_rvalid,
        .o_axil_rdata,
        .o_axil_rresp,
        .i_axil_rready,
        .o_start      ( start ),
        .o_cfg        ( cfg ),
        .i_busy       ( busy ),
        .o_capture_en ( capture_en ),
        .o_rd_idx     ( rd_idx ),
        .i_rd_word    ( rd_word ),
        .i_pkt_count  ( pkt_count )
    );

    // ----------------------------------------------------------------------
    // Packet path
    // ----------------------------------------------------------------------
    packet_playback packet_playback_i (
        .clk,
        .srst,
        .i_start ( start ),
        .i_cfg   ( cfg ),
        .o_busy  ( busy ),
        .o_pkt   ( play_if )
    );

    packet_fifo packet_fifo_i (
        .clk,
        .srst,
        .i_pkt ( play_if ),
        .o_pkt ( cap_if )
    );

    packet_capture packet_capture_i (
        .clk,
        .srst,
        .i_pkt        ( cap_if ),
        .i_capture_en ( capture_en ),
        .i_rd_idx     ( rd_idx ),
        .o_rd_word    ( rd_word ),
        .o_pkt_count  ( pkt_count )
    );

endmodule

// File: verification/tb_proxy_top.sv
`timescale 1ns/1ps

module tb_proxy_top;

    import proxy_regs_pkg::*;
    import packet_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int CYCLE_LIMIT = 20000;
    localparam int POLL_LIMIT  = 200;
    localparam int LCG_SEED    = 92596;

    logic        clk;
    logic        srst;
    logic        axil_awvalid;
    logic [7:0]  axil_awaddr;
    logic        axil_awready;
    logic        axil_wvalid;
    logic [31:0] axil_wdata;
    logic        axil_wready;
    logic        axil_bvalid;
    axil_resp_t  axil_bresp;
    logic        axil_bready;
    logic        axil_arvalid;
    logic [7:0]  axil_araddr;
    logic        axil_arready;
    logic        axil_rvalid;
    logic [31:0] axil_rdata;
    axil_resp_t  axil_rresp;
    logic        axil_rready;

    int unsigned cycles;
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          test_start_errors;
    logic [31:0] lcg_state;
    logic [15:0] exp_count;

    // Comparisons waiting for the checker process
    string       cmp_name_q [$];
    logic [31:0] cmp_exp_q [$];
    logic [31:0] cmp_act_q [$];
    event        cmp_ev;

    proxy_top dut_i (
        .clk            ( clk ),
        .srst           ( srst ),
        .i_axil_awvalid ( axil_awvalid ),
        .i_axil_awaddr  ( axil_awaddr ),
        .o_axil_awready ( axil_awready ),
        .i_axil_wvalid  ( axil_wvalid ),
        .i_axil_wdata   ( axil_wdata ),
        .o_axil_wready  ( axil_wready ),
        .o_axil_bvalid  ( axil_bvalid ),
        .o_axil_bresp   ( axil_bresp ),
        .i_axil_bready  ( axil_bready ),
        .i_axil_arvalid ( axil_arvalid ),
        .i_axil_araddr  ( axil_araddr ),
        .o_axil_arready ( axil_arready ),
        .o_axil_rvalid  ( axil_rvalid ),
        .o_axil_rdata   ( axil_rdata ),
        .o_axil_rresp   ( axil_rresp ),
        .i_axil_rready  ( axil_rready )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Packet word i is the seed plus i, modulo 2^32
    function automatic logic [31:0] expected_word(input logic [31:0] seed, input int idx);
        return seed + 32'(idx);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        cmp_name_q.push_back(name);
        cmp_exp_q.push_back(exp);
        cmp_act_q.push_back(act);
        -> cmp_ev;
    endtask

    // ----------------------------------------------------------------------
    // Checker
    // ----------------------------------------------------------------------
    initial begin
        string       name;
        logic [31:0] exp;
        logic [31:0] act;
        forever begin
            @(cmp_ev);
            while (cmp_act_q.size() > 0) begin
                name = cmp_name_q.pop_front();
                exp  = cmp_exp_q.pop_front();
                act  = cmp_act_q.pop_front();
                if (act !== exp) begin
                    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
                    errors++;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // AXI4-Lite master, called on a falling edge
    // ----------------------------------------------------------------------
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output axil_resp_t resp);
        axil_awvalid = 1'b1;
        axil_awaddr  = addr;
        axil_wvalid  = 1'b1;
        axil_wdata   = data;
        @(negedge clk);
        while (!axil_awready) @(negedge clk);
        // Address and data are accepted in the same cycle
        check_value("o_axil_wready", 32'd1, 32'(axil_wready));
        @(negedge clk);
        axil_awvalid = 1'b0;
        axil_wvalid  = 1'b0;
        while (!axil_bvalid) @(negedge clk);
        resp        = axil_bresp;
        axil_bready = 1'b1;
        @(negedge clk);
        axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output axil_resp_t resp);
        axil_arvalid = 1'b1;
        axil_araddr  = addr;
        @(negedge clk);
        while (!axil_arready) @(negedge clk);
        @(negedge clk);
        axil_arvalid = 1'b0;
        while (!axil_rvalid) @(negedge clk);
        data        = axil_rdata;
        resp        = axil_rresp;
        axil_rready = 1'b1;
        @(negedge clk);
        axil_rready = 1'b0;
    endtask

    task automatic write_check(input logic [7:0] addr, input logic [31:0] data);
        axil_resp_t resp;
        axil_write(addr, data, resp);
        check_value($sformatf("o_axil_bresp @%h", addr), RESP_OKAY, resp);
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        axil_resp_t  resp;
        axil_read(addr, data, resp);
        check_value($sformatf("o_axil_rdata @%h", addr), exp, data);
        check_value($sformatf("o_axil_rresp @%h", addr), RESP_OKAY, resp);
    endtask

    // Poll STATUS until playback is idle and the count has reached its target
    task automatic wait_for_idle(input logic [15:0] count);
        logic [31:0] data = 32'h1;
        axil_resp_t  resp;
        int          polls = 0;
        while ((data[0] || data[31:16] != count) && polls < POLL_LIMIT) begin
            axil_read(REG_STATUS, data, resp);
            polls++;
        end
        if (polls >= POLL_LIMIT) begin
            $display("Playback did not go idle within %0d STATUS polls", POLL_LIMIT);
        end
        check_value("STATUS busy", 32'd0, 32'(data[0]));
        check_value("STATUS packet count", 32'(count), 32'(data[31:16]));
    endtask

    task automatic check_packet(input logic [31:0] seed, input int len);
        logic [31:0] data;
        axil_resp_t  resp;
        for (int i = 0; i < len; i++) begin
            axil_read(CAPTURE_BASE + 8'(i * 4), data, resp);
            check_value($sformatf("capture word %0d", i), expected_word(seed, i), data);
        end
    endtask

    task automatic run_packet(input int len, input logic [31:0] seed);
        write_check(REG_PKT_LEN, 32'(len - 1));
        write_check(REG_SEED, seed);
        write_check(REG_CTRL, 32'h3);
        exp_count++;
        wait_for_idle(exp_count);
        check_packet(seed, len);
    endtask

    task automatic end_test(input int num, input string name);
        // Let the checker drain before counting
        @(negedge clk);
        if (errors == test_start_errors) begin
            tests_ok++;
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_bad++;
            $display("Test %0d %s: %0d errors", num, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // Run length limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run went past %0d clock cycles", CYCLE_LIMIT);
        $display("*** FAILED ***");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------
    initial begin
        axil_resp_t  resp;
        logic [31:0] data;
        logic [31:0] seed;
        int          len;
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        test_start_errors = 0;
        exp_count = '0;
        lcg_state = 32'(LCG_SEED);
        srst = 1'b1;
        axil_awvalid = 1'b0;
        axil_awaddr = '0;
        axil_wvalid = 1'b0;
        axil_wdata = '0;
        axil_bready = 1'b0;
        axil_arvalid = 1'b0;
        axil_araddr = '0;
        axil_rready = 1'b0;
        repeat (4) @(negedge clk);
        srst = 1'b0;
        @(negedge clk);

        read_check(REG_CTRL, 32'h0);
        read_check(REG_PKT_LEN, 32'h0);
        read_check(REG_SEED, 32'h0);
        read_check(REG_STATUS, 32'h0);
        end_test(1, "reset values");

        write_check(REG_PKT_LEN, 32'h0000_ABCD);
        read_check(REG_PKT_LEN, 32'h0000_000D);
        write_check(REG_SEED, 32'hDEAD_BEEF);
        read_check(REG_SEED, 32'hDEAD_BEEF);
        write_check(REG_CTRL, 32'h2);
        read_check(REG_CTRL, 32'h2);
        write_check(REG_CTRL, 32'h0);
        read_check(REG_CTRL, 32'h0);
        end_test(2, "register readback");

        seed = 32'h1234_5678;
        write_check(REG_PKT_LEN, 32'd4);
        write_check(REG_SEED, seed);
        write_check(REG_CTRL, 32'h3);
        // Start bit must not read back
        read_check(REG_CTRL, 32'h2);
        exp_count++;
        wait_for_idle(exp_count);
        check_packet(seed, 5);
        end_test(3, "single packet");

        // Seed near the top so the words wrap
        seed = 32'hFFFF_FFF8;
        write_check(REG_CTRL, 32'h0);
        write_check(REG_PKT_LEN, 32'd15);
        write_check(REG_SEED, seed);
        write_check(REG_CTRL, 32'h1);
        repeat (100) @(negedge clk);
        axil_read(REG_STATUS, data, resp);
        check_value("STATUS busy while stalled", 32'd1, 32'(data[0]));
        check_value("STATUS count while stalled", 32'(exp_count), 32'(data[31:16]));
        write_check(REG_CTRL, 32'h2);
        exp_count++;
        wait_for_idle(exp_count);
        check_packet(seed, 16);
        end_test(4, "back-pressure");

        axil_write(8'h10, 32'h5555_AAAA, resp);
        check_value("o_axil_bresp @10", RESP_SLVERR, resp);
        axil_write(8'h80, 32'h5555_AAAA, resp);
        check_value("o_axil_bresp @80", RESP_SLVERR, resp);
        axil_read(8'h10, data, resp);
        check_value("o_axil_rdata @10", 32'h0, data);
        check_value("o_axil_rresp @10", RESP_SLVERR, resp);
        axil_read(8'h80, data, resp);
        check_value("o_axil_rdata @80", 32'h0, data);
        check_value("o_axil_rresp @80", RESP_SLVERR, resp);
        end_test(5, "unmapped offsets");

        for (int n = 0; n < 10; n++) begin
            lcg_state = lcg_next(lcg_state);
            len = int'(lcg_state[19:16]) + 1;
            lcg_state = lcg_next(lcg_state);
            seed = lcg_state;
            run_packet(len, seed);
        end
        end_test(6, "random packets");

        $display("Tests: %0d ok, %0d with errors, %0d errors in all",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
hw/proxy_regs_pkg.sv
hw/packet_pkg.sv
hw/packet_if.sv
hw/packet_playback.sv
hw/packet_fifo.sv
hw/packet_capture.sv
hw/proxy_regs.sv
hw/proxy_top.sv
verification/tb_proxy_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then grade the log
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_proxy_top -o sim_proxy \
    > build.log 2>&1 \
    && ./obj_dir/sim_proxy > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }

grep -qF "*** PASSED ***" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail, see sim.log"; exit 1; }
